//--- src/rv_mini_cfg.svh
`ifndef RV_MINI_CFG_SVH
`define RV_MINI_CFG_SVH

// Memory depths in 32-bit words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64

`define RV_APB_ADDR_W 12

// Register map, byte offsets on the APB side
`define RV_CTRL_ADDR   'h000
`define RV_STATUS_ADDR 'h004
`define RV_PC_ADDR     'h008
`define RV_IMEM_BASE   'h100
`define RV_DMEM_BASE   'h200

`endif

//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_r3    = 7'b0110011,
        op_ld    = 7'b0000011,
        op_st    = 7'b0100011,
        op_br    = 7'b1100011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_sys   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b      // LUI
    } alu_op_e;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Only word width is supported for loads and stores
    localparam logic [2:0] F3_LW_SW = 3'b010;

endpackage

`default_nettype wire

//--- src/rv_ctrl_pkg.sv
`default_nettype none

`include "rv_mini_cfg.svh"

package rv_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        wb_alu,
        wb_pc4,
        wb_mem
    } wb_sel_e;

    typedef struct packed {
        logic        reg_write;
        logic        pc_rs1_sel;    // 1 selects PC as ALU operand a
        logic        imm_rs2_sel;   // 1 selects the immediate as operand b
        logic        jump;
        logic        branch;
        logic        mem_write;
        wb_sel_e     wb_sel;
        alu_op_e     alu_op;
        logic        halt;
        logic        illegal;
        logic [31:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`RV_APB_ADDR_W-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire logic [31:0] instr,
    output ctrl_t            ctrl
);

    logic [2:0]  funct3;
    logic        f7_alt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // Arithmetic ops share one funct3 map for OP and OP-IMM
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign f7_alt = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;  // Inactive, wb_alu, alu_add

        case (opcode_e'(instr[6:0]))
            op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.imm         = imm_i;
                // Bit 30 only matters for SRAI, it is part of the ADDI immediate
                ctrl.alu_op      = alu_from_f3(funct3, (funct3 == 3'b101) && f7_alt);
            end
            op_r3: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_f3(funct3, f7_alt);
            end
            op_ld: begin
                if (funct3 == F3_LW_SW) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.imm_rs2_sel = 1'b1;
                    ctrl.wb_sel      = wb_mem;
                    ctrl.imm         = imm_i;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            op_st: begin
                if (funct3 == F3_LW_SW) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.imm_rs2_sel = 1'b1;
                    ctrl.imm         = imm_s;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            op_br: begin
                ctrl.branch = 1'b1;   // Compare rs1 with rs2, target PC + imm
                ctrl.alu_op = alu_sub;
                ctrl.imm    = imm_b;
            end
            op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.alu_op      = alu_pass_b;
                ctrl.imm         = imm_u;
            end
            op_auipc: begin
                ctrl.reg_write   = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.imm         = imm_u;
            end
            op_jal: begin
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = wb_pc4;
                ctrl.imm         = imm_j;
            end
            op_jalr: begin
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;  // Target comes from rs1 + imm
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.wb_sel      = wb_pc4;
                ctrl.imm         = imm_i;
            end
            op_sys:  ctrl.halt = 1'b1;
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*; (
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire alu_op_e     alu_op,
    input  wire logic [2:0]  funct3,
    output logic [31:0]      result,
    output logic             br_taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {31'b0, lt_s};
            alu_sltu:   result = {31'b0, lt_u};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // Only meaningful while a branch is decoded
    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = (a == b);
            F3_BNE:  br_taken = (a != b);
            F3_BLT:  br_taken = lt_s;
            F3_BGE:  br_taken = !lt_s;
            F3_BLTU: br_taken = lt_u;
            F3_BGEU: br_taken = !lt_u;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  rs1_addr,
    input  wire logic [4:0]  rs2_addr,
    input  wire logic [4:0]  rd_addr,
    input  wire logic [31:0] rd_data,
    input  wire logic        we,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];  // x0 reads zero
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- src/core_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_mini_cfg.svh"

module core_datapath import rv_ctrl_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      run,
    input  wire ctrl_t                     ctrl,
    input  wire logic [31:0]               rs1_data,
    input  wire logic [31:0]               rs2_data,
    input  wire logic [31:0]               alu_result,
    input  wire logic                      br_taken,
    input  wire logic                      mem_we,
    input  wire logic                      mem_sel_imem,
    input  wire logic [`RV_APB_ADDR_W-3:0] mem_addr,
    input  wire logic [31:0]               mem_wdata,
    output logic [31:0]                    instr,
    output logic [31:0]                    pc,
    output logic [31:0]                    alu_a,
    output logic [31:0]                    alu_b,
    output logic [31:0]                    rd_data,
    output logic                           reg_we,
    output logic [31:0]                    mem_rdata,
    output logic                           halt_event,
    output logic                           illegal_event
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    logic [31:0] imem [`RV_IMEM_WORDS];
    logic [31:0] dmem [`RV_DMEM_WORDS];
    logic [31:0] pc_q;
    logic        run_q;
    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic [31:0] pc_next;
    logic [31:0] dmem_rdata;
    logic        stop;

    // First cycle after start fetches from address 0
    assign pc = (run && !run_q) ? '0 : pc_q;

    assign instr      = imem[pc[IMEM_AW+1:2]];
    assign dmem_rdata = dmem[alu_result[DMEM_AW+1:2]];

    assign alu_a = ctrl.pc_rs1_sel ? pc : rs1_data;
    assign alu_b = ctrl.imm_rs2_sel ? ctrl.imm : rs2_data;

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + ctrl.imm;   // Branches and JAL
    assign stop      = ctrl.halt || ctrl.illegal;

    always_comb begin
        if (stop)                                pc_next = pc;  // PC stays on the halting instruction
        else if (ctrl.jump && ctrl.pc_rs1_sel)   pc_next = br_target;
        else if (ctrl.jump)                      pc_next = {alu_result[31:1], 1'b0};
        else if (ctrl.branch && br_taken)        pc_next = br_target;
        else                                     pc_next = pc_plus4;
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_pc4:  rd_data = pc_plus4;
            wb_mem:  rd_data = dmem_rdata;
            default: rd_data = alu_result;
        endcase
    end

    assign reg_we        = run && ctrl.reg_write;
    assign halt_event    = run && stop;
    assign illegal_event = run && ctrl.illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= '0;
            run_q <= 1'b0;
        end else begin
            run_q <= run;
            if (run) pc_q <= pc_next;
        end
    end

    // Core owns data memory while running, APB side port otherwise
    always_ff @(posedge clk) begin
        if (run && ctrl.mem_write) begin
            dmem[alu_result[DMEM_AW+1:2]] <= rs2_data;
        end else if (!run && mem_we && !mem_sel_imem) begin
            dmem[mem_addr[DMEM_AW-1:0]] <= mem_wdata;
        end
        if (!run && mem_we && mem_sel_imem) imem[mem_addr[IMEM_AW-1:0]] <= mem_wdata;
    end

    assign mem_rdata = mem_sel_imem ? imem[mem_addr[IMEM_AW-1:0]] : dmem[mem_addr[DMEM_AW-1:0]];

endmodule

`default_nettype wire

//--- src/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_mini_cfg.svh"

module apb_regs import rv_ctrl_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire apb_req_t                  apb_req,
    input  wire logic                      halt_event,
    input  wire logic                      illegal_event,
    input  wire logic [31:0]               pc,
    input  wire logic [31:0]               mem_rdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           run,
    output logic                           mem_we,
    output logic                           mem_sel_imem,
    output logic [`RV_APB_ADDR_W-3:0]      mem_addr,
    output logic [31:0]                    mem_wdata
);

    localparam int AW = `RV_APB_ADDR_W;
    localparam logic [AW-1:0] IMEM_BASE = AW'(`RV_IMEM_BASE);
    localparam logic [AW-1:0] DMEM_BASE = AW'(`RV_DMEM_BASE);
    localparam logic [AW-1:0] IMEM_END  = AW'(`RV_IMEM_BASE + 4 * `RV_IMEM_WORDS);
    localparam logic [AW-1:0] DMEM_END  = AW'(`RV_DMEM_BASE + 4 * `RV_DMEM_WORDS);

    logic          access;
    logic          ctrl_hit, status_hit, pc_hit, imem_hit, dmem_hit;
    logic          mem_hit, unmapped;
    logic [AW-1:0] imem_off, dmem_off;
    logic          halted, illegal;

    assign access     = apb_req.psel && apb_req.penable;
    assign ctrl_hit   = apb_req.paddr == AW'(`RV_CTRL_ADDR);
    assign status_hit = apb_req.paddr == AW'(`RV_STATUS_ADDR);
    assign pc_hit     = apb_req.paddr == AW'(`RV_PC_ADDR);
    assign imem_hit   = apb_req.paddr >= IMEM_BASE && apb_req.paddr < IMEM_END;
    assign dmem_hit   = apb_req.paddr >= DMEM_BASE && apb_req.paddr < DMEM_END;
    assign mem_hit    = imem_hit || dmem_hit;
    assign unmapped   = !(ctrl_hit || status_hit || pc_hit || mem_hit);

    assign pready  = 1'b1;                                  // No wait states
    assign pslverr = access && (unmapped || (mem_hit && run));

    // Side port into the memories, word addressed within each window
    assign imem_off     = apb_req.paddr - IMEM_BASE;
    assign dmem_off     = apb_req.paddr - DMEM_BASE;
    assign mem_sel_imem = imem_hit;
    assign mem_addr     = imem_hit ? imem_off[AW-1:2] : dmem_off[AW-1:2];
    assign mem_wdata    = apb_req.pwdata;
    assign mem_we       = access && apb_req.pwrite && mem_hit && !run;

    always_comb begin
        prdata = '0;
        if (ctrl_hit)              prdata = {31'b0, run};
        else if (status_hit)       prdata = {30'b0, illegal, halted};
        else if (pc_hit)           prdata = pc;
        else if (mem_hit && !run)  prdata = mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run     <= 1'b0;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            if (halt_event) begin
                run     <= 1'b0;
                halted  <= 1'b1;
                illegal <= illegal_event;
            end
            // A CTRL write on the same edge takes priority over a halt
            if (access && apb_req.pwrite && ctrl_hit) begin
                run <= apb_req.pwdata[0];
                if (apb_req.pwdata[0]) begin
                    halted  <= 1'b0;
                    illegal <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/rv_mini_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_mini_cfg.svh"

module rv_mini_top import rv_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire apb_req_t apb_req,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr
);

    ctrl_t                     ctrl;
    logic [31:0]               instr, pc, alu_a, alu_b, alu_result;
    logic [31:0]               rs1_data, rs2_data, rd_data;
    logic [31:0]               mem_rdata, mem_wdata;
    logic [`RV_APB_ADDR_W-3:0] mem_addr;
    logic                      run, br_taken, reg_we;
    logic                      mem_we, mem_sel_imem, halt_event, illegal_event;

    apb_regs apb_regs_inst (
        .clk, .reset, .apb_req, .halt_event, .illegal_event, .pc, .mem_rdata,
        .prdata, .pready, .pslverr, .run, .mem_we, .mem_sel_imem, .mem_addr, .mem_wdata
    );

    core_datapath core_datapath_inst (
        .clk, .reset, .run, .ctrl, .rs1_data, .rs2_data, .alu_result, .br_taken,
        .mem_we, .mem_sel_imem, .mem_addr, .mem_wdata, .instr, .pc, .alu_a, .alu_b,
        .rd_data, .reg_we, .mem_rdata, .halt_event, .illegal_event
    );

    control_unit control_unit_inst (.instr, .ctrl);

    alu alu_inst (
        .a(alu_a), .b(alu_b), .alu_op(ctrl.alu_op), .funct3(instr[14:12]),
        .result(alu_result), .br_taken
    );

    reg_file reg_file_inst (
        .clk, .reset,
        .rs1_addr(instr[19:15]), .rs2_addr(instr[24:20]), .rd_addr(instr[11:7]),
        .rd_data, .we(reg_we), .rs1_data, .rs2_data
    );

endmodule

`default_nettype wire

//--- dv/rv_mini_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_mini_cfg.svh"

module rv_mini_tb import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

    localparam int AW       = `RV_APB_ADDR_W;
    localparam int MAX_ROWS = 32;
    localparam int HALT_CYCLES = 200;
    localparam logic [31:0] ECALL = 32'h0000_0073;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Test table with one entry per program
    string       row_name     [MAX_ROWS];
    logic [31:0] row_prog     [MAX_ROWS][8];
    int          row_len      [MAX_ROWS];
    logic [31:0] row_exp      [MAX_ROWS];
    logic        row_pre      [MAX_ROWS];  // Data word loaded before the run
    int          row_pre_addr [MAX_ROWS];
    logic [31:0] row_pre_data [MAX_ROWS];
    int          n_rows;

    logic [31:0] prog_q [$];    // Program being built
    logic        pre_pending;
    int          pre_addr;
    logic [31:0] pre_data;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_value;

    rv_mini_top rv_mini_top_inst (
        .clk, .reset, .apb_req, .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_r3};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input opcode_e op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_LW_SW, imm[4:0], op_st};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_br};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd, input opcode_e op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    function automatic logic [AW-1:0] imem_addr(input int w);
        return AW'(`RV_IMEM_BASE + 4 * w);
    endfunction

    function automatic logic [AW-1:0] dmem_addr(input int w);
        return AW'(`RV_DMEM_BASE + 4 * w);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", what, got, exp);
            errors++;
        end
    endtask

    // One APB transfer as a setup cycle then an access cycle
    task automatic bus_transfer(input logic wr, input logic [AW-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 4) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("APB transfer to address %h never completed", addr);
            errors++;
        end
        rdata = prdata;   // Sampled mid access cycle
        err   = pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_word(input logic [AW-1:0] addr, input logic [31:0] data,
                              output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic read_word(input logic [AW-1:0] addr, output logic [31:0] data,
                             output logic err);
        bus_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_halted(input string name, output logic ok);
        logic [31:0] status;
        logic        err;
        int          cycles;
        status = '0;
        cycles = 0;
        while (!status[0] && cycles < HALT_CYCLES) begin
            read_word(AW'(`RV_STATUS_ADDR), status, err);
            cycles += 3;
        end
        ok = status[0];
        if (!ok) begin
            $display("Timeout: %s did not halt within %0d cycles", name, HALT_CYCLES);
            errors++;
            write_word(AW'(`RV_CTRL_ADDR), 32'h0, err);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog_q.push_back(word);
    endtask

    // Result goes to the data word with the row's index
    task automatic emit_epilogue(input int rs);
        emit(s_type(4 * n_rows, rs, 0));
        emit(ECALL);
    endtask

    task automatic preload(input int w, input logic [31:0] data);
        pre_pending = 1'b1;
        pre_addr    = w;
        pre_data    = data;
    endtask

    task automatic add_row(input string name, input logic [31:0] expected);
        row_name[n_rows] = name;
        row_len[n_rows]  = prog_q.size();
        foreach (prog_q[i]) row_prog[n_rows][i] = prog_q[i];
        row_exp[n_rows]      = expected;
        row_pre[n_rows]      = pre_pending;
        row_pre_addr[n_rows] = pre_addr;
        row_pre_data[n_rows] = pre_data;
        prog_q.delete();
        pre_pending = 1'b0;
        n_rows++;
    endtask

    // Taken path writes 2 and fall-through writes 1
    task automatic branch_row(input string name, input logic [2:0] f3, input int a,
                              input int b, input logic taken);
        emit(i_type(a, 0, 3'b000, 1, op_imm));
        emit(i_type(b, 0, 3'b000, 2, op_imm));
        emit(b_type(12, 2, 1, f3));                // PC 8 to PC 20
        emit(i_type(1, 0, 3'b000, 3, op_imm));
        emit(j_type(8, 0));
        emit(i_type(2, 0, 3'b000, 3, op_imm));
        emit_epilogue(3);
        add_row(name, taken ? 32'd2 : 32'd1);
    endtask

    task automatic build_table();
        n_rows      = 0;
        pre_pending = 1'b0;
        emit(i_type(-5, 0, 3'b000, 1, op_imm));
        emit(i_type(12, 0, 3'b000, 2, op_imm));
        emit(r_type(7'h20, 2, 1, 3'b000, 3));      // SUB
        emit(r_type(7'h00, 3, 3, 3'b000, 3));
        emit_epilogue(3);
        add_row("add_sub", 32'hffff_ffde);
        emit(i_type(-64, 0, 3'b000, 1, op_imm));
        emit(i_type(3, 0, 3'b000, 2, op_imm));
        emit(r_type(7'h20, 2, 1, 3'b101, 3));      // SRA
        emit(r_type(7'h00, 2, 1, 3'b101, 4));      // SRL
        emit(r_type(7'h00, 4, 3, 3'b100, 5));
        emit_epilogue(5);
        add_row("sra_srl", 32'he000_0000);
        emit(i_type(-64, 0, 3'b000, 1, op_imm));
        emit(i_type(12'h404, 1, 3'b101, 3, op_imm)); // SRAI 4
        emit(i_type(4, 1, 3'b101, 4, op_imm));       // SRLI 4
        emit(r_type(7'h20, 4, 3, 3'b000, 5));
        emit_epilogue(5);
        add_row("srai_srli", 32'hf000_0000);
        emit(i_type(-1, 0, 3'b000, 1, op_imm));
        emit(i_type(1, 0, 3'b000, 2, op_imm));
        emit(r_type(7'h00, 2, 1, 3'b010, 3));      // SLT
        emit(r_type(7'h00, 2, 1, 3'b011, 4));      // SLTU
        emit(i_type(1, 3, 3'b001, 3, op_imm));
        emit(r_type(7'h00, 4, 3, 3'b110, 3));
        emit_epilogue(3);
        add_row("slt_sltu", 32'h0000_0002);
        emit(i_type(12'h0f0, 0, 3'b000, 1, op_imm));
        emit(i_type(12'h0ff, 1, 3'b100, 2, op_imm)); // XORI
        emit(i_type(12'h700, 2, 3'b110, 3, op_imm)); // ORI
        emit(i_type(12'h30c, 3, 3'b111, 4, op_imm)); // ANDI
        emit(i_type(12'h400, 4, 3'b011, 5, op_imm)); // SLTIU
        emit(r_type(7'h00, 5, 4, 3'b000, 4));
        emit_epilogue(4);
        add_row("logic_imm", 32'h0000_030d);
        emit(i_type(3, 0, 3'b000, 1, op_imm));
        emit(i_type(5, 0, 3'b000, 2, op_imm));
        emit(r_type(7'h00, 2, 1, 3'b001, 3));      // SLL
        emit(r_type(7'h00, 1, 3, 3'b100, 4));      // XOR
        emit(r_type(7'h00, 3, 4, 3'b111, 5));      // AND
        emit(r_type(7'h00, 2, 5, 3'b110, 5));      // OR
        emit_epilogue(5);
        add_row("sll_logic", 32'h0000_0065);
        emit(u_type(20'h12345, 1, op_lui));
        emit(i_type(12'h678, 1, 3'b000, 1, op_imm));
        emit_epilogue(1);
        add_row("lui", 32'h1234_5678);
        emit(i_type(0, 0, 3'b000, 0, op_imm));
        emit(i_type(0, 0, 3'b000, 0, op_imm));
        emit(u_type(20'habcde, 1, op_auipc));      // At PC 8
        emit_epilogue(1);
        add_row("auipc", 32'habcd_e008);
        branch_row("beq_taken", F3_BEQ, 5, 5, 1'b1);
        branch_row("beq_not", F3_BEQ, 5, 6, 1'b0);
        branch_row("bne_taken", F3_BNE, 5, 6, 1'b1);
        branch_row("bne_not", F3_BNE, 5, 5, 1'b0);
        branch_row("blt_taken", F3_BLT, -3, 2, 1'b1);
        branch_row("blt_not", F3_BLT, 2, -3, 1'b0);
        branch_row("bge_taken", F3_BGE, 2, -3, 1'b1);
        branch_row("bge_not", F3_BGE, -3, 2, 1'b0);
        branch_row("bltu_taken", F3_BLTU, 2, -3, 1'b1);
        branch_row("bltu_not", F3_BLTU, -3, 2, 1'b0);
        branch_row("bgeu_taken", F3_BGEU, -3, 2, 1'b1);
        branch_row("bgeu_not", F3_BGEU, 2, -3, 1'b0);
        emit(i_type(0, 0, 3'b000, 3, op_imm));
        emit(j_type(12, 1));                       // PC 4 to PC 16 with link 8
        emit(i_type(-1, 0, 3'b000, 3, op_imm));
        emit(ECALL);
        emit(r_type(7'h00, 1, 3, 3'b000, 3));
        emit_epilogue(3);
        add_row("jal", 32'h0000_0008);
        emit(i_type(17, 0, 3'b000, 2, op_imm));
        emit(i_type(0, 2, 3'b000, 1, op_jalr));    // Target 17 lands on 16
        emit(i_type(-1, 0, 3'b000, 1, op_imm));
        emit(ECALL);
        emit(u_type(0, 4, op_auipc));
        emit(r_type(7'h00, 4, 1, 3'b000, 3));
        emit_epilogue(3);
        add_row("jalr", 32'h0000_0018);
        preload(40, 32'h1234_0000);
        emit(i_type(160, 0, F3_LW_SW, 1, op_ld));
        emit(i_type(12'h055, 1, 3'b000, 1, op_imm));
        emit(s_type(160, 1, 0));
        emit(i_type(160, 0, F3_LW_SW, 2, op_ld));
        emit_epilogue(2);
        add_row("lw_sw", 32'h1234_0055);
    endtask

    task automatic fill_memories();
        logic err;
        for (int w = 0; w < `RV_IMEM_WORDS; w++) write_word(imem_addr(w), $urandom, err);
        for (int w = 0; w < `RV_DMEM_WORDS; w++) write_word(dmem_addr(w), $urandom, err);
    endtask

    task automatic run_table();
        logic [31:0] got;
        logic        err;
        logic        ok;
        int          errs_before;
        for (int r = 0; r < n_rows; r++) begin
            errs_before = errors;
            if (row_pre[r]) write_word(dmem_addr(row_pre_addr[r]), row_pre_data[r], err);
            for (int w = 0; w < row_len[r]; w++) write_word(imem_addr(w), row_prog[r][w], err);
            write_word(AW'(`RV_CTRL_ADDR), 32'h1, err);
            wait_halted(row_name[r], ok);
            if (ok) begin
                read_word(dmem_addr(r), got, err);
                check_value($sformatf("%s dmem[%0d]", row_name[r], r), got, row_exp[r]);
            end
            report_test(row_name[r], errs_before);
        end
    endtask

    task automatic check_illegal();
        logic [31:0] got;
        logic        err;
        logic        ok;
        int          errs_before;
        errs_before = errors;
        write_word(imem_addr(0), i_type(1, 0, 3'b000, 1, op_imm), err);
        write_word(imem_addr(1), 32'hffff_ffff, err);   // Opcode 7f is not decoded
        write_word(AW'(`RV_CTRL_ADDR), 32'h1, err);
        wait_halted("illegal", ok);
        if (ok) begin
            read_word(AW'(`RV_STATUS_ADDR), got, err);
            check_value("status", got, 32'h3);
        end
        report_test("illegal", errs_before);
    endtask

    task automatic check_busy_write();
        logic [31:0] got;
        logic [31:0] loop_word;
        logic        err;
        int          errs_before;
        errs_before = errors;
        loop_word   = j_type(0, 0);                     // Jumps to itself forever
        write_word(imem_addr(0), i_type(0, 0, 3'b000, 0, op_imm), err);
        write_word(imem_addr(1), loop_word, err);       // Core spins at PC 4
        write_word(AW'(`RV_CTRL_ADDR), 32'h1, err);
        write_word(imem_addr(1), $urandom, err);
        check_value("pslverr", 32'(err), 32'h1);
        read_word(AW'(`RV_STATUS_ADDR), got, err);
        check_value("status", got, 32'h0);
        write_word(AW'(`RV_CTRL_ADDR), 32'h0, err);
        read_word(AW'(`RV_CTRL_ADDR), got, err);
        check_value("ctrl", got, 32'h0);
        read_word(AW'(`RV_PC_ADDR), got, err);
        check_value("pc", got, 32'h4);
        read_word(imem_addr(1), got, err);              // Refused write left no trace
        check_value("imem[1]", got, loop_word);
        check_value("pslverr", 32'(err), 32'h0);
        report_test("busy_write", errs_before);
    endtask

    initial begin
        seed_value   = $urandom(32'hf033_68ce);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        apb_req      = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        build_table();
        fill_memories();
        run_table();
        check_illegal();
        check_busy_write();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_mini.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/control_unit.sv
src/alu.sv
src/reg_file.sv
src/core_datapath.sv
src/apb_regs.sv
src/rv_mini_top.sv
dv/rv_mini_tb.sv
